/* rtl/opnd_pkg.sv */
/*
 * Shared encodings for the operand-supply pipeline slice.
 * Imported by the RTL and the testbench for source selects, ALU ops and lane indices.
 */

package opnd_pkg;

	////////////////////
	// Operand sources
	////////////////////

	// Values kept as in the classic OR1200 operand mux
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} opnd_sel_e;

	////////////////////
	// ALU operations
	////////////////////

	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		// Load B straight through, e.g. an immediate
		ALU_PASS_B = 3'd5
	} alu_op_e;

	// Operand lanes, A first
	localparam int NUM_LANES = 2;
	localparam int LANE_A    = 0;
	localparam int LANE_B    = 1;

endpackage

/* rtl/reg_file.sv */
/*
 * Integer register file, two combinational read ports and one write port.
 * Written only at the WB commit edge; register 0 is kept at zero.
 */

`timescale 1ns/1ns

module reg_file #(
	parameter  int WIDTH    = 32,
	parameter  int NUM_REGS = 16,
	localparam int AW       = $clog2(NUM_REGS)
) (
	input  logic             clk,
	input  logic             rst_n,
	// Read addresses from ID
	input  logic [AW-1:0]    rs_a,
	input  logic [AW-1:0]    rs_b,
	// Commit port from WB
	input  logic             wr_en,
	input  logic [AW-1:0]    wr_addr,
	input  logic [WIDTH-1:0] wr_data,
	output logic [WIDTH-1:0] rd_data_a,
	output logic [WIDTH-1:0] rd_data_b
);

	logic [WIDTH-1:0] regs [NUM_REGS];

	////////////////////
	// Write port
	////////////////////

	// Whole array cleared on reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	////////////////////
	// Read ports
	////////////////////

	// No write-through here, WB forwarding covers the commit cycle
	assign rd_data_a = regs[rs_a];
	assign rd_data_b = regs[rs_b];

	// EX drops writes to r0, so none may reach the array
	a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> (wr_addr != '0));

endmodule

/* rtl/fwd_ctrl.sv */
/*
 * Operand source selection for the ID stage.
 * Compares each ID source register with the EX and WB destinations
 * and picks immediate, EX forward, WB forward or register file per lane.
 */

`timescale 1ns/1ns

module fwd_ctrl #(
	parameter int AW = 4
) (
	// ID source registers
	input  logic [AW-1:0]        rs_a,
	input  logic [AW-1:0]        rs_b,
	input  logic                 use_imm,
	// Producers in flight
	input  logic                 ex_we,
	input  logic [AW-1:0]        ex_rd,
	input  logic                 wb_we,
	input  logic [AW-1:0]        wb_rd,
	output opnd_pkg::opnd_sel_e  lane_sel [opnd_pkg::NUM_LANES]
);

	import opnd_pkg::*;

	// Source register seen by each lane
	logic [AW-1:0] lane_rs [NUM_LANES];

	assign lane_rs[LANE_A] = rs_a;
	assign lane_rs[LANE_B] = rs_b;

	////////////////////
	// Select priority
	////////////////////

	// Immediate first, B lane only
	// Then EX, which holds the younger value, then WB
	// r0 never matches a live producer since its write enable is dropped in EX
	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			if (i == LANE_B && use_imm) begin
				lane_sel[i] = SEL_IMM;
			end else if (ex_we && ex_rd == lane_rs[i]) begin
				lane_sel[i] = SEL_EX_FORW;
			end else if (wb_we && wb_rd == lane_rs[i]) begin
				lane_sel[i] = SEL_WB_FORW;
			end else begin
				lane_sel[i] = SEL_RF;
			end
		end
	end

	// Operand A has no immediate path
	always_comb begin
		a_a_no_imm: assert #0 (lane_sel[LANE_A] != SEL_IMM)
			else $error("fwd_ctrl: lane A selected the immediate");
	end

endmodule

/* rtl/operand_lane.sv */
/*
 * One operand lane: source mux into the EX operand register.
 * An operand captured at the start of an ID freeze is held until the
 * freeze ends, so forwarding sources moving on cannot overwrite it.
 */

`timescale 1ns/1ns

module operand_lane #(
	parameter int WIDTH = 32
) (
	input  logic                clk,
	input  logic                rst_n,
	// Pipeline freezes
	input  logic                id_freeze,
	input  logic                ex_freeze,
	// Source select from forwarding control
	input  opnd_pkg::opnd_sel_e sel,
	// Candidate sources
	input  logic [WIDTH-1:0]    rf_data,
	input  logic [WIDTH-1:0]    imm,
	input  logic [WIDTH-1:0]    ex_forw,
	input  logic [WIDTH-1:0]    wb_forw,
	// Operand into EX
	output logic [WIDTH-1:0]    operand
);

	import opnd_pkg::*;

	logic [WIDTH-1:0] muxed;
	// Operand already taken during the current ID freeze
	logic             saved;

	////////////////////
	// Source mux
	////////////////////

	always_comb begin
		case (sel)
			SEL_IMM:     muxed = imm;
			SEL_EX_FORW: muxed = ex_forw;
			SEL_WB_FORW: muxed = wb_forw;
			default:     muxed = rf_data;
		endcase
	end

	////////////////////
	// Operand register
	////////////////////

	// Nothing moves while EX is frozen
	// First edge of an ID freeze captures and marks saved
	// Saved holds the value until both freezes are low
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			operand <= '0;
			saved   <= 1'b0;
		end else if (!ex_freeze) begin
			if (!saved) begin
				operand <= muxed;
				saved   <= id_freeze;
			end else if (!id_freeze) begin
				saved   <= 1'b0;
			end
		end
	end

	////////////////////
	// Checks
	////////////////////

	// EX freeze holds the operand
	a_ex_freeze_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ex_freeze |=> $stable(operand));

endmodule

/* rtl/exec_unit.sv */
/*
 * Execute and writeback stages.
 * Holds the EX control, computes the ALU result from both lanes,
 * registers it into WB and strobes the register file commit.
 */

`timescale 1ns/1ns

module exec_unit #(
	parameter int WIDTH = 32,
	parameter int AW    = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              id_freeze,
	input  logic              ex_freeze,
	// Decoded control from ID
	input  opnd_pkg::alu_op_e id_op,
	input  logic [AW-1:0]     id_rd,
	input  logic              id_we,
	// Lane operands
	input  logic [WIDTH-1:0]  operand_a,
	input  logic [WIDTH-1:0]  operand_b,
	// EX stage view, used for forwarding
	output logic              ex_we,
	output logic [AW-1:0]     ex_rd,
	output logic [WIDTH-1:0]  ex_forw,
	// WB stage, wb_data is also the WB forward
	output logic              wb_we,
	output logic [AW-1:0]     wb_rd,
	output logic [WIDTH-1:0]  wb_data,
	output logic              commit
);

	import opnd_pkg::*;

	alu_op_e ex_op;

	////////////////////
	// EX stage
	////////////////////

	// ID freeze sends a bubble, only the write enable is cleared
	// r0 destinations lose their write enable here
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_op <= ALU_ADD;
			ex_rd <= '0;
			ex_we <= 1'b0;
		end else if (!ex_freeze) begin
			if (id_freeze) begin
				ex_we <= 1'b0;
			end else begin
				ex_op <= id_op;
				ex_rd <= id_rd;
				ex_we <= id_we && (id_rd != '0);
			end
		end
	end

	// ALU
	always_comb begin
		case (ex_op)
			ALU_ADD:    ex_forw = operand_a + operand_b;
			ALU_SUB:    ex_forw = operand_a - operand_b;
			ALU_AND:    ex_forw = operand_a & operand_b;
			ALU_OR:     ex_forw = operand_a | operand_b;
			ALU_XOR:    ex_forw = operand_a ^ operand_b;
			ALU_PASS_B: ex_forw = operand_b;
			default:    ex_forw = '0;
		endcase
	end

	////////////////////
	// WB stage
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_we   <= 1'b0;
			wb_rd   <= '0;
			wb_data <= '0;
		end else if (!ex_freeze) begin
			wb_we   <= ex_we;
			wb_rd   <= ex_rd;
			wb_data <= ex_forw;
		end
	end

	// Register file write at the next unfrozen edge
	assign commit = wb_we && !ex_freeze;

	// No live write to r0 in EX
	a_ex_r0: assert property (@(posedge clk) disable iff (!rst_n)
		(ex_rd == '0) |-> !ex_we);

endmodule

/* rtl/pipe_core.sv */
/*
 * Top of the operand-supply slice: register file, forwarding control,
 * NUM_LANES operand lanes and the EX/WB stages.
 * Driven by a decoder with one instruction per cycle, paced by the freeze pair.
 */

`timescale 1ns/1ns

module pipe_core #(
	parameter  int WIDTH    = 32,
	// Power of two
	parameter  int NUM_REGS = 16,
	localparam int AW       = $clog2(NUM_REGS)
) (
	input  logic              clk,
	input  logic              rst_n,
	// Pipeline freezes
	input  logic              id_freeze,
	input  logic              ex_freeze,
	// Decoded instruction in ID
	input  logic [AW-1:0]     id_rs_a,
	input  logic [AW-1:0]     id_rs_b,
	input  logic [AW-1:0]     id_rd,
	input  logic              id_we,
	input  logic              id_use_imm,
	input  logic [WIDTH-1:0]  id_imm,
	input  opnd_pkg::alu_op_e id_op,
	// Instruction in WB
	output logic              wb_we,
	output logic [AW-1:0]     wb_rd,
	output logic [WIDTH-1:0]  wb_data
);

	import opnd_pkg::*;

	// Per-lane register file values and operands
	logic [WIDTH-1:0] lane_rf_data [NUM_LANES];
	logic [WIDTH-1:0] operand      [NUM_LANES];
	opnd_sel_e        lane_sel     [NUM_LANES];

	// EX producer
	logic             ex_we;
	logic [AW-1:0]    ex_rd;
	logic [WIDTH-1:0] ex_forw;
	logic             commit;

	////////////////////
	// ID stage
	////////////////////

	// Written from WB on commit
	reg_file #(
		.WIDTH    (WIDTH),
		.NUM_REGS (NUM_REGS)
	) u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rs_a      (id_rs_a),
		.rs_b      (id_rs_b),
		.wr_en     (commit),
		.wr_addr   (wb_rd),
		.wr_data   (wb_data),
		.rd_data_a (lane_rf_data[LANE_A]),
		.rd_data_b (lane_rf_data[LANE_B])
	);

	fwd_ctrl #(
		.AW (AW)
	) u_fwd_ctrl (
		.rs_a     (id_rs_a),
		.rs_b     (id_rs_b),
		.use_imm  (id_use_imm),
		.ex_we    (ex_we),
		.ex_rd    (ex_rd),
		.wb_we    (wb_we),
		.wb_rd    (wb_rd),
		.lane_sel (lane_sel)
	);

	// One lane per operand, WB result doubles as the WB forward
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		operand_lane #(
			.WIDTH (WIDTH)
		) u_lane (
			.clk       (clk),
			.rst_n     (rst_n),
			.id_freeze (id_freeze),
			.ex_freeze (ex_freeze),
			.sel       (lane_sel[i]),
			.rf_data   (lane_rf_data[i]),
			.imm       (id_imm),
			.ex_forw   (ex_forw),
			.wb_forw   (wb_data),
			.operand   (operand[i])
		);
	end

	////////////////////
	// EX and WB stages
	////////////////////

	exec_unit #(
		.WIDTH (WIDTH),
		.AW    (AW)
	) u_exec_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.id_op     (id_op),
		.id_rd     (id_rd),
		.id_we     (id_we),
		.operand_a (operand[LANE_A]),
		.operand_b (operand[LANE_B]),
		.ex_we     (ex_we),
		.ex_rd     (ex_rd),
		.ex_forw   (ex_forw),
		.wb_we     (wb_we),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data),
		.commit    (commit)
	);

endmodule

/* sim/tb_pipe_core.sv */
/*
 * Testbench for pipe_core acting as the decoder.
 * Keeps a register model and checks each WB commit with concurrent assertions.
 */

`timescale 1ns/1ns

module tb_pipe_core;

	import opnd_pkg::*;

	localparam int WIDTH          = 32;
	localparam int AW             = 4;
	localparam int TIMEOUT_CYCLES = 1500;

	logic             clk        = 1'b0;
	logic             rst_n      = 1'b0;
	logic             id_freeze  = 1'b0;
	logic             ex_freeze  = 1'b0;
	logic [AW-1:0]    id_rs_a    = '0;
	logic [AW-1:0]    id_rs_b    = '0;
	logic [AW-1:0]    id_rd      = '0;
	logic             id_we      = 1'b0;
	logic             id_use_imm = 1'b0;
	logic [WIDTH-1:0] id_imm     = '0;
	alu_op_e          id_op      = ALU_ADD;
	logic             wb_we;
	logic [AW-1:0]    wb_rd;
	logic [WIDTH-1:0] wb_data;

	// Architectural registers and expected writebacks, oldest first
	logic [WIDTH-1:0]      model [16] = '{default: '0};
	logic [AW-1:0]         exp_rd_q [$];
	logic [WIDTH-1:0]      exp_data_q [$];
	logic                  head_valid = 1'b0;
	logic [AW-1:0]         head_rd    = '0;
	logic [WIDTH-1:0]      head_data  = '0;
	// WB outputs one edge back
	logic [AW+WIDTH:0]     wb_q       = '0;
	int                    seed       = 18;
	int                    cycles     = 0;
	// Freeze odds in percent, and forced freeze cycles
	int                    id_pct     = 0;
	int                    ex_pct     = 0;
	int                    id_hold    = 0;
	int                    ex_hold    = 0;
	string                 test_name  = "reset";

	always #2 clk = ~clk;

	pipe_core #(
		.WIDTH    (WIDTH),
		.NUM_REGS (16)
	) u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.id_freeze  (id_freeze),
		.ex_freeze  (ex_freeze),
		.id_rs_a    (id_rs_a),
		.id_rs_b    (id_rs_b),
		.id_rd      (id_rd),
		.id_we      (id_we),
		.id_use_imm (id_use_imm),
		.id_imm     (id_imm),
		.id_op      (id_op),
		.wb_we      (wb_we),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

	////////////////////
	// Checks
	////////////////////

	// Quiet WB during reset and just after
	a_reset_wb: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |=> !wb_we)
		else report_mismatch("reset wb_we", 64'(0), 64'($sampled(wb_we)));

	a_commit_known: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_we && !ex_freeze) |-> head_valid)
		else report_failure($sformatf("%s: commit to r%0d with no writeback expected",
			test_name, $sampled(wb_rd)));

	a_commit_rd: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_we && !ex_freeze && head_valid) |-> (wb_rd == head_rd))
		else report_mismatch({test_name, " wb_rd"}, 64'($sampled(head_rd)),
			64'($sampled(wb_rd)));

	a_commit_data: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_we && !ex_freeze && head_valid) |-> (wb_data == head_data))
		else report_mismatch({test_name, " wb_data"}, 64'($sampled(head_data)),
			64'($sampled(wb_data)));

	// r0 is never a live destination
	a_no_r0: assert property (@(posedge clk) disable iff (!rst_n) wb_we |-> (wb_rd != '0))
		else report_failure($sformatf("%s: write to r0 reached WB", test_name));

	// EX freeze holds the whole WB stage
	a_ex_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ex_freeze |=> ({wb_we, wb_rd, wb_data} == wb_q))
		else report_mismatch({test_name, " wb under ex_freeze"}, 64'($sampled(wb_q)),
			64'($sampled({wb_we, wb_rd, wb_data})));

	task automatic stop_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
		stop_run();
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		stop_run();
	endtask

	// Hang guard, about three times the stimulus length
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			report_failure($sformatf("timeout after %0d cycles in %s", cycles, test_name));
		end
	end

	////////////////////
	// Reference model
	////////////////////

	function automatic logic [WIDTH-1:0] alu_ref(input alu_op_e op, input logic [WIDTH-1:0] a,
		input logic [WIDTH-1:0] b);
		case (op)
			ALU_ADD:    return a + b;
			ALU_SUB:    return a - b;
			ALU_AND:    return a & b;
			ALU_OR:     return a | b;
			ALU_XOR:    return a ^ b;
			ALU_PASS_B: return b;
			default:    return '0;
		endcase
	endfunction

	// Commit pops the head, an accepted writing instruction pushes its result
	always @(posedge clk) begin
		logic [WIDTH-1:0] opnd_b;
		logic [WIDTH-1:0] res;
		if (rst_n && wb_we && !ex_freeze && exp_rd_q.size() > 0) begin
			void'(exp_rd_q.pop_front());
			void'(exp_data_q.pop_front());
		end
		if (rst_n && !id_freeze && !ex_freeze && id_we && id_rd != '0) begin
			opnd_b = id_use_imm ? id_imm : model[id_rs_b];
			res    = alu_ref(id_op, model[id_rs_a], opnd_b);
			model[id_rd] = res;
			exp_rd_q.push_back(id_rd);
			exp_data_q.push_back(res);
		end
		head_valid <= exp_rd_q.size() > 0;
		head_rd    <= (exp_rd_q.size() > 0) ? exp_rd_q[0] : '0;
		head_data  <= (exp_data_q.size() > 0) ? exp_data_q[0] : '0;
		wb_q       <= {wb_we, wb_rd, wb_data};
	end

	////////////////////
	// Stimulus
	////////////////////

	// Holds one instruction in ID until an edge with both freezes low
	task automatic present(input logic [AW-1:0] rs_a, input logic [AW-1:0] rs_b,
		input logic [AW-1:0] rd, input logic we, input logic use_imm,
		input logic [WIDTH-1:0] imm, input alu_op_e op);
		logic accepted;
		accepted   = 1'b0;
		id_rs_a    = rs_a;
		id_rs_b    = rs_b;
		id_rd      = rd;
		id_we      = we;
		id_use_imm = use_imm;
		id_imm     = imm;
		id_op      = op;
		while (!accepted) begin
			id_freeze = (id_hold > 0) || (($unsigned($random(seed)) % 100) < id_pct);
			ex_freeze = (ex_hold > 0) || (($unsigned($random(seed)) % 100) < ex_pct);
			id_hold   = (id_hold > 0) ? id_hold - 1 : 0;
			ex_hold   = (ex_hold > 0) ? ex_hold - 1 : 0;
			accepted  = !id_freeze && !ex_freeze;
			@(posedge clk);
			#1;
		end
	endtask

	// Mask narrows the register range to raise dependency density
	task automatic random_instr(input logic [AW-1:0] mask);
		logic [31:0] r;
		logic [31:0] imm;
		r   = $random(seed);
		imm = $random(seed);
		present(r[3:0] & mask, r[7:4] & mask, r[11:8] & mask, r[14:12] != 3'd0, r[15], imm,
			alu_op_e'(3'(r[31:16] % 16'd6)));
	endtask

	initial begin
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// Distance one through EX, distance two through WB
		test_name = "forwarding";
		present(4'd0, 4'd0, 4'd1, 1'b1, 1'b1, 32'h11, ALU_PASS_B);
		present(4'd1, 4'd0, 4'd2, 1'b1, 1'b1, 32'h100, ALU_ADD);
		present(4'd2, 4'd1, 4'd3, 1'b1, 1'b0, 32'h0, ALU_SUB);
		present(4'd3, 4'd2, 4'd4, 1'b1, 1'b0, 32'h0, ALU_XOR);
		present(4'd4, 4'd0, 4'd0, 1'b0, 1'b0, 32'h0, ALU_ADD);
		present(4'd4, 4'd3, 4'd5, 1'b1, 1'b0, 32'h0, ALU_OR);
		test_name = "imm_r0";
		present(4'd0, 4'd0, 4'd0, 1'b1, 1'b1, 32'hdead, ALU_PASS_B);
		present(4'd0, 4'd0, 4'd6, 1'b1, 1'b1, 32'h7, ALU_ADD);
		present(4'd0, 4'd6, 4'd7, 1'b1, 1'b0, 32'h0, ALU_AND);
		// Consumer held in ID while its producer moves on to WB
		test_name = "id_freeze";
		present(4'd6, 4'd1, 4'd8, 1'b1, 1'b0, 32'h0, ALU_ADD);
		id_hold = 2;
		present(4'd8, 4'd8, 4'd9, 1'b1, 1'b0, 32'h0, ALU_ADD);
		id_pct = 30;
		repeat (80) random_instr(4'h7);
		id_pct = 0;
		test_name = "ex_freeze";
		ex_hold = 3;
		present(4'd9, 4'd2, 4'd10, 1'b1, 1'b0, 32'h0, ALU_SUB);
		ex_pct = 30;
		repeat (40) random_instr(4'h7);
		test_name = "random";
		id_pct = 20;
		ex_pct = 20;
		repeat (200) random_instr(4'hf);
		test_name = "drain";
		id_we     = 1'b0;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		while (exp_rd_q.size() != 0) begin
			@(posedge clk);
			#1;
		end
		// A few idle cycles so a stray commit still trips the checks
		repeat (4) @(posedge clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* files.f */
rtl/opnd_pkg.sv
rtl/reg_file.sv
rtl/fwd_ctrl.sv
rtl/operand_lane.sv
rtl/exec_unit.sv
rtl/pipe_core.sv
sim/tb_pipe_core.sv

/* Bender.yml */
package:
  name: pipe_core

sources:
  - rtl/opnd_pkg.sv
  - rtl/reg_file.sv
  - rtl/fwd_ctrl.sv
  - rtl/operand_lane.sv
  - rtl/exec_unit.sv
  - rtl/pipe_core.sv
  - target: simulation
    files:
      - sim/tb_pipe_core.sv
